/* src/memoryPkg.sv */
/*
 * Memory map package for the 16-bit system bus.
 * Address views, region codes and peripheral register offsets
 * shared by the controller and its peripherals.
 */
`default_nettype none

package memoryPkg;

	// RAM view: bank select on the top two bits
	typedef struct packed {
		logic [1:0]  bank;
		logic [13:0] offset;
	} ramView_t;

	// I/O view: one byte of region, one byte of register
	typedef struct packed {
		logic [7:0] region;
		logic [7:0] regOffset;
	} ioView_t;

	typedef union packed {
		ramView_t ram;
		ioView_t  io;
	} memAddr_u;

	localparam logic [7:0] UART_REGION = 8'h10;	// 0x10xx
	localparam logic [7:0] GPIO_REGION = 8'h11;	// 0x11xx
	localparam logic [3:0] ROM_TOP     = 4'h0;	// 0x0000 - 0x0fff

	localparam logic [7:0] UART_TXDATA = 8'd0;
	localparam logic [7:0] UART_STATUS = 8'd1;	// bit 0 busy

	localparam logic [7:0] GPIO_OUTREG = 8'd0;
	localparam logic [7:0] GPIO_INREG  = 8'd1;

endpackage

`default_nettype wire

/* src/periphBus.sv */
/*
 * Register bus between the memory controller and one peripheral.
 * Offset, write data and strobe go out, read data comes back
 * combinationally from the peripheral registers.
 */
`timescale 1ns/1ns
`default_nettype none

interface periphBus #(parameter int BITS = 16);

	logic [7:0]      offset;	// register within the region
	logic [BITS-1:0] wrData;
	logic [BITS-1:0] rdData;
	logic            wr;	// one cycle per write

	modport controller (output offset, output wrData, output wr, input rdData);

	modport peripheral (input offset, input wrData, input wr, output rdData);

endinterface

`default_nettype wire

/* src/bootRom.sv */
/*
 * Boot ROM.
 * Synchronous read-only memory, contents loaded from bootRom.hex,
 * words not listed in the file read as zero.
 */
`timescale 1ns/1ns
`default_nettype none

module bootRom #(
	parameter int BITS = 16,
	parameter int ADDRESS_BITS = 12
)
(
	input wire logic                    CLK,
	input wire logic [ADDRESS_BITS-1:0] address,
	output logic     [BITS-1:0]         dataOut
);

localparam int WORDS = 2 ** ADDRESS_BITS;

logic [BITS-1:0] mem [WORDS];

initial begin
	for (int i = 0; i < WORDS; i++) begin
		mem[i] = '0;	// clear before partial load
	end
	$readmemh("bootRom.hex", mem);
end

always_ff @(posedge CLK) begin
	dataOut <= mem[address];	// one cycle read
end

endmodule

`default_nettype wire

/* src/ramBank.sv */
/*
 * RAM bank.
 * Synchronous single-port memory, depth set by ADDRESS_BITS.
 * A write cycle returns the word held before the write.
 */
`timescale 1ns/1ns
`default_nettype none

module ramBank #(
	parameter int BITS = 16,
	parameter int ADDRESS_BITS = 14
)
(
	input wire logic                    CLK,
	input wire logic [ADDRESS_BITS-1:0] address,
	input wire logic [BITS-1:0]         dataIn,
	output logic     [BITS-1:0]         dataOut,
	input wire logic                    wrEn
);

logic [BITS-1:0] mem [2 ** ADDRESS_BITS];

always_ff @(posedge CLK) begin
	if (wrEn) begin
		mem[address] <= dataIn;
	end
	dataOut <= mem[address];	// read-before-write
end

endmodule

`default_nettype wire

/* src/uartTx.sv */
/*
 * UART transmitter, 8N1.
 * A write to TXDATA while idle loads a frame of start bit, eight data
 * bits LSB first and stop bit. STATUS bit 0 shows the frame in flight.
 */
`timescale 1ns/1ns
`default_nettype none

module uartTx
	import memoryPkg::*;
#(
	parameter int BITS = 16,
	parameter int CLOCK_FREQ = 10_000_000,
	parameter int BAUD_RATE = 115_200
)
(
	input wire logic CLK,
	input wire logic RSTb,
	periphBus.peripheral bus,
	output logic txd
);

localparam int DIVISOR = CLOCK_FREQ / BAUD_RATE;	// clocks per bit
localparam int CNT_BITS = $clog2(DIVISOR + 1);

logic [CNT_BITS-1:0] baudCount;
logic [3:0] bitCount;	// 0 start, 1..8 data, 9 stop
logic [8:0] shiftReg;	// stop bit comes in with the idle fill
logic [7:0] txData;	// last byte accepted
logic busy;
logic startTx;

assign startTx = bus.wr && (bus.offset == UART_TXDATA) && !busy;	// dropped when busy
assign txd = shiftReg[0];

always_ff @(posedge CLK) begin
	if (!RSTb) begin
		busy <= 1'b0;
		baudCount <= '0;
		bitCount <= '0;
		shiftReg <= '1;	// line idles high
		txData <= '0;
	end else if (startTx) begin
		busy <= 1'b1;
		baudCount <= '0;
		bitCount <= '0;
		shiftReg <= {bus.wrData[7:0], 1'b0};
		txData <= bus.wrData[7:0];
	end else if (busy) begin
		if (baudCount == CNT_BITS'(DIVISOR - 1)) begin
			baudCount <= '0;
			shiftReg <= {1'b1, shiftReg[8:1]};	// refill with idle level
			if (bitCount == 4'd9) begin
				busy <= 1'b0;	// end of stop bit
			end else begin
				bitCount <= bitCount + 4'd1;
			end
		end else begin
			baudCount <= baudCount + 1'b1;
		end
	end
end

always_comb begin
	case (bus.offset)
		UART_TXDATA: bus.rdData = {{(BITS - 8){1'b0}}, txData};
		UART_STATUS: bus.rdData = {{(BITS - 1){1'b0}}, busy};
		default:     bus.rdData = '0;
	endcase
end

endmodule

`default_nettype wire

/* src/gpioPort.sv */
/*
 * GPIO port.
 * OUTREG drives the output pins and reads back, INREG returns the
 * input pins after a two-flop synchroniser.
 */
`timescale 1ns/1ns
`default_nettype none

module gpioPort
	import memoryPkg::*;
#(
	parameter int BITS = 16,
	parameter int OUT_BITS = 4,
	parameter int IN_BITS = 6
)
(
	input wire logic                CLK,
	input wire logic                RSTb,
	periphBus.peripheral            bus,
	output logic     [OUT_BITS-1:0] pinsOut,
	input wire logic [IN_BITS-1:0]  pinsIn
);

logic [OUT_BITS-1:0] outReg;
logic [IN_BITS-1:0] syncA;	// first stage, may go metastable
logic [IN_BITS-1:0] syncB;

assign pinsOut = outReg;

always_ff @(posedge CLK) begin
	if (!RSTb) begin
		outReg <= '0;
	end else if (bus.wr && bus.offset == GPIO_OUTREG) begin
		outReg <= bus.wrData[OUT_BITS-1:0];
	end
end

always_ff @(posedge CLK) begin
	syncA <= pinsIn;
	syncB <= syncA;
end

always_comb begin
	case (bus.offset)
		GPIO_OUTREG: bus.rdData = {{(BITS - OUT_BITS){1'b0}}, outReg};
		GPIO_INREG:  bus.rdData = {{(BITS - IN_BITS){1'b0}}, syncB};	// zero-extended
		default:     bus.rdData = '0;
	endcase
end

endmodule

`default_nettype wire

/* src/memoryController.sv */
/*
 * Memory controller for the 16-bit system bus.
 * Decodes the address onto boot ROM, four RAM banks, UART and GPIO,
 * steers write strobes and returns read data one clock after the
 * address. Peripheral words are registered here so every target
 * shows the same latency.
 */
`timescale 1ns/1ns
`default_nettype none

module memoryController
	import memoryPkg::*;
#(
	parameter int BITS = 16,
	parameter int ADDRESS_BITS = 16,
	parameter int CLOCK_FREQ = 10_000_000,
	parameter int BAUD_RATE = 115_200,
	parameter int GPIO_OUT_BITS = 4,
	parameter int GPIO_IN_BITS = 6
)
(
	input wire logic                     CLK,
	input wire logic                     RSTb,
	input wire logic [ADDRESS_BITS-1:0]  address,
	input wire logic [BITS-1:0]          dataIn,
	output logic     [BITS-1:0]          dataOut,
	input wire logic                     memWR,	// write strobe
	input wire logic                     memRD,	// read strobe
	output logic                         uartTxd,
	output logic     [GPIO_OUT_BITS-1:0] gpioOut,
	input wire logic [GPIO_IN_BITS-1:0]  gpioIn
);

localparam int ROM_BITS = ADDRESS_BITS - 4;	// 4k words
localparam int BANK0_BITS = ADDRESS_BITS - 2;
localparam int BANK_BITS = ADDRESS_BITS - 1;

memAddr_u addrView;
memAddr_u addrReg;	// address of the word being returned
logic [3:0] ramWr;
logic uartWr;
logic gpioWr;
logic [BITS-1:0] romData;
logic [BITS-1:0] ramData [4];
logic [BITS-1:0] periphData;
logic [BITS-1:0] periphNext;

periphBus #(.BITS(BITS)) uartBus ();
periphBus #(.BITS(BITS)) gpioBus ();

assign addrView = address;

// write steering and peripheral read select in priority order
always_comb begin
	ramWr = '0;
	uartWr = 1'b0;
	gpioWr = 1'b0;
	periphNext = periphData;
	if (addrView.io.region == UART_REGION) begin
		uartWr = memWR;
		periphNext = uartBus.rdData;
	end else if (addrView.io.region == GPIO_REGION) begin
		gpioWr = memWR;
		periphNext = gpioBus.rdData;
	end else if (addrView.io.region[7:4] == ROM_TOP) begin
		ramWr[0] = memWR;	// shadow write under the ROM
	end else if (addrView.io.region[7:4] inside {4'h1, 4'h2}) begin
		ramWr = '0;	// unmapped gap
	end else begin
		ramWr[addrView.ram.bank] = memWR;
	end
end

always_ff @(posedge CLK) begin
	if (!RSTb) begin
		periphData <= '0;
		addrReg <= '0;
	end else begin
		periphData <= periphNext;
		addrReg <= addrView;
	end
end

// return word picked by the registered address
always_comb begin
	if (addrReg.io.region == UART_REGION || addrReg.io.region == GPIO_REGION) begin
		dataOut = periphData;
	end else if (addrReg.io.region[7:4] == ROM_TOP) begin
		dataOut = romData;
	end else if (addrReg.io.region[7:4] inside {4'h1, 4'h2}) begin
		dataOut = '0;
	end else begin
		dataOut = ramData[addrReg.ram.bank];
	end
end

assign uartBus.offset = addrView.io.regOffset;
assign uartBus.wrData = dataIn;
assign uartBus.wr = uartWr;

assign gpioBus.offset = addrView.io.regOffset;
assign gpioBus.wrData = dataIn;
assign gpioBus.wr = gpioWr;

bootRom #(.BITS(BITS), .ADDRESS_BITS(ROM_BITS)) rom (
	.CLK(CLK),
	.address(addrView.ram.offset[ROM_BITS-1:0]),
	.dataOut(romData)
);

ramBank #(.BITS(BITS), .ADDRESS_BITS(BANK0_BITS)) bank0 (
	.CLK(CLK),
	.address(addrView.ram.offset),
	.dataIn(dataIn),
	.dataOut(ramData[0]),
	.wrEn(ramWr[0])
);

// upper banks take one extra address bit
for (genvar g = 1; g < 4; g++) begin : gBank
	ramBank #(.BITS(BITS), .ADDRESS_BITS(BANK_BITS)) bank (
		.CLK(CLK),
		.address(address[BANK_BITS-1:0]),
		.dataIn(dataIn),
		.dataOut(ramData[g]),
		.wrEn(ramWr[g])
	);
end

uartTx #(.BITS(BITS), .CLOCK_FREQ(CLOCK_FREQ), .BAUD_RATE(BAUD_RATE)) uart (
	.CLK(CLK),
	.RSTb(RSTb),
	.bus(uartBus.peripheral),
	.txd(uartTxd)
);

gpioPort #(.BITS(BITS), .OUT_BITS(GPIO_OUT_BITS), .IN_BITS(GPIO_IN_BITS)) gpio (
	.CLK(CLK),
	.RSTb(RSTb),
	.bus(gpioBus.peripheral),
	.pinsOut(gpioOut),
	.pinsIn(gpioIn)
);

endmodule

`default_nettype wire

/* verification/clockGen.sv */
/*
 * Testbench clock and reset.
 * Free-running clock and an active-low reset held for a
 * fixed number of cycles.
 */
`timescale 1ns/1ns
`default_nettype none

module clockGen #(
	parameter int PERIOD = 100,
	parameter int RESET_CYCLES = 5
)
(
	output logic CLK,
	output logic RSTb
);

initial begin
	CLK = 1'b0;
	forever #(PERIOD / 2) CLK = ~CLK;
end

initial begin
	RSTb = 1'b0;
	repeat (RESET_CYCLES) @(posedge CLK);
	#10 RSTb = 1'b1;	// released just after an edge
end

endmodule

`default_nettype wire

/* verification/memoryControllerTb.sv */
/*
 * Testbench for the memory controller.
 * Builds a table of bus operations with expected data from a model of
 * the memory map, applies it one operation per clock and decodes the
 * UART line with a receiver that samples at bit centres.
 */
`timescale 1ns/1ns
`default_nettype none

module memoryControllerTb;

localparam int BIT_CYCLES = 10;	// 10 MHz clock at 1 Mbaud
localparam int FRAME_CYCLES = 10 * BIT_CYCLES;
localparam int MAX_OPS = 100;
localparam int TIMEOUT_CYCLES = 10 * (MAX_OPS + 3 * FRAME_CYCLES);
localparam logic [15:0] ROM_WORDS [16] = '{
	16'h3a0f, 16'hc001, 16'h5a5a, 16'h0123, 16'h4567, 16'h89ab, 16'hcdef, 16'h7e11,
	16'h0f0f, 16'hf00d, 16'h1234, 16'hbeef, 16'h2468, 16'h1357, 16'h8000, 16'hffff
};

typedef enum logic [2:0] {OP_READ, OP_WRITE, OP_IDLE, OP_PINS, OP_POLL, OP_GPIOOUT} opKind_e;

logic CLK;
logic RSTb;
logic [15:0] address;
logic [15:0] dataIn;
logic [15:0] dataOut;
logic memWR;
logic memRD;
logic uartTxd;
logic [3:0] gpioOut;
logic [5:0] gpioIn;

opKind_e opKind [MAX_OPS];
logic [15:0] opAddr [MAX_OPS];
logic [15:0] opData [MAX_OPS];
logic [15:0] opExpect [MAX_OPS];
int opCount;
logic [15:0] ramModel [logic [15:0]];	// keyed by bus address
logic [3:0] gpioModel;
logic [7:0] txExpected [$];	// bytes the UART must send
logic [7:0] rxByte;
int framesQueued;
int frameCount;
int checkCount;
int errorCount;
int cycleCount;
int pollCount;

clockGen #(.PERIOD(100), .RESET_CYCLES(5)) clocks (.CLK(CLK), .RSTb(RSTb));

memoryController #(
	.BITS(16), .ADDRESS_BITS(16), .CLOCK_FREQ(10_000_000), .BAUD_RATE(1_000_000),
	.GPIO_OUT_BITS(4), .GPIO_IN_BITS(6)
) uut (
	.CLK(CLK), .RSTb(RSTb), .address(address), .dataIn(dataIn), .dataOut(dataOut),
	.memWR(memWR), .memRD(memRD), .uartTxd(uartTxd), .gpioOut(gpioOut), .gpioIn(gpioIn)
);

function automatic logic [15:0] bankAddr(int bank, logic [15:0] offset);
	if (bank == 0) begin
		return 16'h3000 | offset;	// lower bank 0 space is ROM or unmapped
	end
	return {2'(bank), 14'h0} | offset;
endfunction

task automatic addOp(opKind_e kind, logic [15:0] addr, logic [15:0] data, logic [15:0] expected);
	opKind[opCount] = kind;
	opAddr[opCount] = addr;
	opData[opCount] = data;
	opExpect[opCount] = expected;
	opCount++;
endtask

task automatic writeRam(logic [15:0] addr, logic [15:0] data);
	ramModel[addr] = data;
	addOp(OP_WRITE, addr, data, 16'h0);
endtask

task automatic buildTable();
	logic [15:0] offsetA;
	logic [15:0] offsetB;
	logic [15:0] pins;
	logic [15:0] word;
	addOp(OP_READ, 16'h1001, 16'h0, 16'h0);	// UART idle after reset
	for (int i = 0; i < 16; i++) begin
		addOp(OP_READ, 16'(i), 16'h0, ROM_WORDS[i]);
	end
	addOp(OP_READ, 16'h0010, 16'h0, 16'h0);	// past the image
	addOp(OP_READ, 16'h0fff, 16'h0, 16'h0);
	addOp(OP_WRITE, 16'h0005, ~ROM_WORDS[5], 16'h0);	// hidden bank 0 write
	addOp(OP_READ, 16'h0005, 16'h0, ROM_WORDS[5]);
	offsetA = 16'($urandom) & 16'h0fff;
	offsetB = 16'($urandom) & 16'h0fff;
	for (int b = 0; b < 4; b++) begin
		writeRam(bankAddr(b, offsetA), 16'($urandom));
		writeRam(bankAddr(b, offsetB), 16'($urandom));
	end
	for (int b = 0; b < 4; b++) begin
		addOp(OP_READ, bankAddr(b, offsetA), 16'h0, ramModel[bankAddr(b, offsetA)]);
		addOp(OP_READ, bankAddr(b, offsetB), 16'h0, ramModel[bankAddr(b, offsetB)]);
	end
	word = 16'($urandom);
	gpioModel = word[3:0];
	addOp(OP_WRITE, 16'h1100, word, 16'h0);
	addOp(OP_GPIOOUT, 16'h0, 16'h0, {12'h0, gpioModel});
	addOp(OP_READ, 16'h1100, 16'h0, {12'h0, gpioModel});
	pins = 16'($urandom) & 16'h003f;
	for (int n = 0; n < 2; n++) begin
		addOp(OP_PINS, 16'h0, pins, 16'h0);
		addOp(OP_IDLE, 16'h0, 16'h0, 16'h0);
		addOp(OP_IDLE, 16'h0, 16'h0, 16'h0);
		addOp(OP_READ, 16'h1101, 16'h0, pins);
		pins = pins ^ 16'h003f;	// every pin toggles
	end
	addOp(OP_WRITE, 16'h1000, 16'h00a5, 16'h0);
	txExpected.push_back(8'ha5);
	addOp(OP_READ, 16'h1001, 16'h0, 16'h0001);
	addOp(OP_WRITE, 16'h1000, 16'h005a, 16'h0);	// dropped while busy
	addOp(OP_READ, 16'h1000, 16'h0, 16'h00a5);
	addOp(OP_POLL, 16'h1001, 16'h0, 16'h0);	// frame end seen with the read strobe low
	addOp(OP_READ, 16'h1200, 16'h0, 16'h0);
	addOp(OP_READ, 16'h1fff, 16'h0, 16'h0);
	addOp(OP_READ, 16'h2000, 16'h0, 16'h0);
	addOp(OP_READ, 16'h2fff, 16'h0, 16'h0);
	addOp(OP_WRITE, 16'h1200, 16'($urandom), 16'h0);
	addOp(OP_WRITE, 16'h1201, 16'($urandom), 16'h0);
	addOp(OP_WRITE, 16'h2000 | offsetA, 16'($urandom), 16'h0);
	addOp(OP_WRITE, 16'h2fff, 16'($urandom), 16'h0);
	for (int b = 0; b < 4; b++) begin
		addOp(OP_READ, bankAddr(b, offsetA), 16'h0, ramModel[bankAddr(b, offsetA)]);
	end
	addOp(OP_READ, 16'h1100, 16'h0, {12'h0, gpioModel});
	addOp(OP_GPIOOUT, 16'h0, 16'h0, {12'h0, gpioModel});
	addOp(OP_READ, 16'h1001, 16'h0, 16'h0);
	addOp(OP_READ, 16'h1000, 16'h0, 16'h00a5);
	framesQueued = txExpected.size();
endtask

// entered 10 ns after an edge and left at the same point one or more cycles on
task automatic applyOp(int idx);
	memWR = (opKind[idx] == OP_WRITE);
	memRD = (opKind[idx] == OP_READ);
	address = opAddr[idx];
	dataIn = opData[idx];
	if (opKind[idx] == OP_PINS) begin
		gpioIn = opData[idx][5:0];
	end
	@(posedge CLK);
	#5;
	if (opKind[idx] == OP_POLL) begin
		pollCount = 0;
		while (dataOut !== opExpect[idx] && pollCount < 3 * FRAME_CYCLES) begin
			pollCount++;
			@(posedge CLK);
			#5;
		end
		checkCount++;
		assert (pollCount < 3 * FRAME_CYCLES) else begin
			$display("address %h never returned %h while polling", opAddr[idx], opExpect[idx]);
			errorCount++;
		end
	end else if (opKind[idx] == OP_READ) begin
		checkCount++;
		assert (dataOut === opExpect[idx]) else begin
			$display("[ERROR] dataOut at %h: got %h, expected %h",
				opAddr[idx], dataOut, opExpect[idx]);
			errorCount++;
		end
	end else if (opKind[idx] == OP_GPIOOUT) begin
		checkCount++;
		assert (gpioOut === opExpect[idx][3:0]) else begin
			$display("[ERROR] gpioOut: got %h, expected %h", gpioOut, opExpect[idx][3:0]);
			errorCount++;
		end
	end
	#5;
endtask

task automatic checkLine(logic level, string what);
	checkCount++;
	assert (uartTxd === level) else begin
		$display("[ERROR] uartTxd %s: got %h, expected %h", what, uartTxd, level);
		errorCount++;
	end
endtask

// UART receiver sampling half a clock before each bit centre
initial begin
	frameCount = 0;
	wait (RSTb === 1'b1);
	forever begin
		@(negedge uartTxd);
		frameCount++;
		repeat (BIT_CYCLES / 2) @(negedge CLK);
		checkLine(1'b0, "start bit");
		for (int b = 0; b < 8; b++) begin
			repeat (BIT_CYCLES) @(negedge CLK);
			rxByte[b] = uartTxd;	// LSB first
		end
		repeat (BIT_CYCLES) @(negedge CLK);
		checkLine(1'b1, "stop bit");
		checkCount++;
		assert (txExpected.size() > 0) else begin
			$display("UART sent frame %0d that no accepted write asked for", frameCount);
			errorCount++;
		end
		if (txExpected.size() > 0) begin
			assert (rxByte == txExpected[0]) else begin
				$display("[ERROR] uartTxd byte: got %h, expected %h", rxByte, txExpected[0]);
				errorCount++;
			end
			void'(txExpected.pop_front());
		end
	end
end

initial begin
	cycleCount = 0;
	while (cycleCount < TIMEOUT_CYCLES) begin
		@(posedge CLK);
		cycleCount++;
	end
	$display("run stopped by timeout after %0d cycles", cycleCount);
	$display("FAIL: see errors above");
	$finish;
end

initial begin
	address = 16'h0;
	dataIn = 16'h0;
	memWR = 1'b0;
	memRD = 1'b0;
	gpioIn = 6'h0;
	checkCount = 0;
	errorCount = 0;
	opCount = 0;
	gpioModel = 4'h0;
	void'($urandom(32'h7a07_2998));
	buildTable();
	wait (RSTb === 1'b1);
	@(posedge CLK);
	#10;
	checkCount += 2;
	assert (uartTxd === 1'b1) else begin
		$display("[ERROR] uartTxd after reset: got %h, expected 1", uartTxd);
		errorCount++;
	end
	assert (gpioOut === 4'h0) else begin
		$display("[ERROR] gpioOut after reset: got %h, expected 0", gpioOut);
		errorCount++;
	end
	for (int i = 0; i < opCount; i++) begin
		applyOp(i);
	end
	repeat (2 * BIT_CYCLES) @(posedge CLK);	// room for a stray second frame
	checkCount++;
	assert (frameCount == framesQueued && txExpected.size() == 0) else begin
		$display("UART sent %0d frames where %0d were expected", frameCount, framesQueued);
		errorCount++;
	end
	$display("checks: %0d, errors: %0d", checkCount, errorCount);
	if (errorCount == 0) begin
		$display("PASS: all tests");
	end else begin
		$display("FAIL: see errors above");
	end
	$finish;
end

endmodule

`default_nettype wire

/* src/bootRom.hex */
// boot image words in hex from address 0
3a0f
c001
5a5a
0123
4567
89ab
cdef
7e11
0f0f
f00d
1234
beef
2468
1357
8000
ffff

/* src.f */
src/memoryPkg.sv
src/periphBus.sv
src/bootRom.sv
src/ramBank.sv
src/uartTx.sv
src/gpioPort.sv
src/memoryController.sv
verification/clockGen.sv
verification/memoryControllerTb.sv

/* run.sh */
#!/bin/sh
# Verilator build and run of the memory controller testbench.
# The boot ROM loads bootRom.hex from the working directory, so the
# simulation binary runs from inside src/.
rm -f sim.log &&
verilator --binary --assert --timescale 1ns/1ns -j 0 --top-module memoryControllerTb \
	-f src.f -o memCtrlSim &&
(cd src && ../obj_dir/memCtrlSim > ../sim.log 2>&1)
grep -qx "PASS: all tests" sim.log && echo "simulation passed" ||
	{ echo "simulation failed, see sim.log"; exit 1; }
